/* lsu_pkg.sv */
// shared types for the load/store unit and its SRAM slave
// op codes follow the RV32 load/store set plus a pass-through op
// size and response codes use the AXI encodings
// misaligned accesses that cross a word boundary are not handled
package lsu_pkg;

	// data and address width
	localparam int XLEN = 32;

	// memory stage operation
	typedef enum logic [3:0] {
		// no bus access, ALU result passes through
		OP_NONE = 4'd0,
		OP_LB   = 4'd1,
		OP_LH   = 4'd2,
		OP_LW   = 4'd3,
		OP_LBU  = 4'd4,
		OP_LHU  = 4'd5,
		OP_SB   = 4'd6,
		OP_SH   = 4'd7,
		OP_SW   = 4'd8
	} lsu_op_e;

	// transfer size, bytes = 2**size
	typedef enum logic [2:0] {
		SIZE_1 = 3'd0,
		SIZE_2 = 3'd1,
		SIZE_4 = 3'd2
	} axi_size_e;

	// response code
	// EXOKAY and DECERR never produced here
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	// request into the unit
	// store data travels beside it on its own port
	typedef struct packed {
		lsu_op_e           op;
		// effective address from the ALU
		logic [XLEN-1:0]   addr;
		// destination register
		logic [4:0]        rd;
	} lsu_req_t;

	// result towards write-back
	typedef struct packed {
		logic [4:0]        rd;
		// load value, address for pass-through, zero for stores
		logic [XLEN-1:0]   data;
		// set on any non-OKAY bus response
		logic              err;
	} lsu_rsp_t;

endpackage

/* lsu_axi_if.sv */
// AXI4-Lite style bus between the load/store unit and the SRAM
// no IDs, no bursts, one transaction in flight
// valid holds with stable payload until its transfer
`timescale 1ns/100ps

interface lsu_axi_if;
	import lsu_pkg::*;

	// read address
	logic [XLEN-1:0]   araddr;
	axi_size_e         arsize;
	logic              arvalid;
	logic              arready;

	// read data
	logic [XLEN-1:0]   rdata;
	axi_resp_e         rresp;
	logic              rvalid;
	logic              rready;

	// write address
	logic [XLEN-1:0]   awaddr;
	axi_size_e         awsize;
	logic              awvalid;
	logic              awready;

	// write data, one strobe bit per byte lane
	logic [XLEN-1:0]   wdata;
	logic [XLEN/8-1:0] wstrb;
	logic              wvalid;
	logic              wready;

	// write response
	axi_resp_e         bresp;
	logic              bvalid;
	logic              bready;

	modport master (
		output araddr, arsize, arvalid, input arready,
		input rdata, rresp, rvalid, output rready,
		output awaddr, awsize, awvalid, input awready,
		output wdata, wstrb, wvalid, input wready,
		input bresp, bvalid, output bready
	);

	modport slave (
		input araddr, arsize, arvalid, output arready,
		output rdata, rresp, rvalid, input rready,
		input awaddr, awsize, awvalid, output awready,
		input wdata, wstrb, wvalid, output wready,
		output bresp, bvalid, input bready
	);

endinterface

/* lsu_data_align.sv */
// byte lane steering between the register file and a 32-bit bus
// lanes always shift by the low two address bits
// a halfword or word that crosses the word boundary gives undefined data
// purely combinational
`timescale 1ns/100ps

module lsu_data_align (
	input  lsu_pkg::lsu_op_e          op_i,
	input  logic [1:0]                addr_lo_i,
	input  logic [lsu_pkg::XLEN-1:0]  store_data_i,
	input  logic [lsu_pkg::XLEN-1:0]  rdata_i,
	output logic [lsu_pkg::XLEN-1:0]  wdata_o,
	output logic [3:0]                wstrb_o,
	output lsu_pkg::axi_size_e        size_o,
	output logic [lsu_pkg::XLEN-1:0]  load_data_o
);
	import lsu_pkg::*;

	// byte offset as a bit shift
	logic [4:0]      lane_shift;
	// strobe before the lane shift
	logic [3:0]      base_strb;
	// addressed lane moved down to bit 0
	logic [XLEN-1:0] lane_data;

	assign lane_shift = {addr_lo_i, 3'b000};

	// transfer size from the access width
	always_comb begin
		case (op_i)
			OP_LB, OP_LBU, OP_SB: begin
				size_o = SIZE_1;
			end
			OP_LH, OP_LHU, OP_SH: begin
				size_o = SIZE_2;
			end
			default: begin
				size_o = SIZE_4;
			end
		endcase
	end

	// store side
	always_comb begin
		case (op_i)
			OP_SB: begin
				base_strb = 4'b0001;
			end
			OP_SH: begin
				base_strb = 4'b0011;
			end
			OP_SW: begin
				base_strb = 4'b1111;
			end
			// loads and pass-through never write
			default: begin
				base_strb = 4'b0000;
			end
		endcase
	end

	// data and strobe move up into the addressed lanes
	assign wdata_o = store_data_i << lane_shift;
	assign wstrb_o = base_strb << addr_lo_i;

	// load side
	assign lane_data = rdata_i >> lane_shift;

	always_comb begin
		case (op_i)
			OP_LB: begin
				load_data_o = {{24{lane_data[7]}}, lane_data[7:0]};
			end
			OP_LH: begin
				load_data_o = {{16{lane_data[15]}}, lane_data[15:0]};
			end
			OP_LBU: begin
				load_data_o = {24'd0, lane_data[7:0]};
			end
			OP_LHU: begin
				load_data_o = {16'd0, lane_data[15:0]};
			end
			// LW, whole word as shifted
			default: begin
				load_data_o = lane_data;
			end
		endcase
	end

endmodule

/* lsu_ctrl.sv */
// load/store controller, bus master side
// one request in flight, req_ready_o only while idle
// result holds until write-back takes it
// AW and W are raised together and may transfer in different cycles
`timescale 1ns/100ps

module lsu_ctrl (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      req_valid_i,
	output logic                      req_ready_o,
	input  lsu_pkg::lsu_req_t         req_i,
	input  logic [lsu_pkg::XLEN-1:0]  req_wdata_i,
	output logic                      rsp_valid_o,
	input  logic                      rsp_ready_i,
	output lsu_pkg::lsu_rsp_t         rsp_o,
	lsu_axi_if.master                 bus
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {
		// waiting for a request
		S_IDLE,
		// AR or AW/W presented
		S_ADDR,
		// waiting for R or B
		S_DATA,
		// result presented to write-back
		S_HOLD
	} state_e;

	state_e          state_q;
	state_e          state_d;
	lsu_req_t        req_q;
	logic [XLEN-1:0] wdata_q;
	logic            aw_done_q;
	logic            w_done_q;
	logic [XLEN-1:0] data_q;
	logic            err_q;

	logic            accept;
	logic            is_load;
	logic            is_store;
	logic            ar_fire;
	logic            aw_fire;
	logic            w_fire;
	logic            r_fire;
	logic            b_fire;
	logic [XLEN-1:0] load_data;

	// decode of the held request
	assign is_load  = req_q.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign is_store = req_q.op inside {OP_SB, OP_SH, OP_SW};

	assign req_ready_o = (state_q == S_IDLE);
	assign accept      = req_valid_i & req_ready_o;
	assign rsp_valid_o = (state_q == S_HOLD);

	// bus valids and readies from the state
	assign bus.arvalid = (state_q == S_ADDR) & is_load;
	assign bus.awvalid = (state_q == S_ADDR) & is_store & ~aw_done_q;
	assign bus.wvalid  = (state_q == S_ADDR) & is_store & ~w_done_q;
	assign bus.rready  = (state_q == S_DATA) & is_load;
	assign bus.bready  = (state_q == S_DATA) & is_store;

	assign ar_fire = bus.arvalid & bus.arready;
	assign aw_fire = bus.awvalid & bus.awready;
	assign w_fire  = bus.wvalid & bus.wready;
	assign r_fire  = bus.rvalid & bus.rready;
	assign b_fire  = bus.bvalid & bus.bready;

	// address is the full byte address, lanes come from the aligner
	assign bus.araddr = req_q.addr;
	assign bus.awaddr = req_q.addr;

	lsu_data_align lsu_data_align_i (
		.op_i         (req_q.op),
		.addr_lo_i    (req_q.addr[1:0]),
		.store_data_i (wdata_q),
		.rdata_i      (bus.rdata),
		.wdata_o      (bus.wdata),
		.wstrb_o      (bus.wstrb),
		.size_o       (bus.arsize),
		.load_data_o  (load_data)
	);

	// same size on both address channels
	assign bus.awsize = bus.arsize;

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				// anything that is not a load or store passes straight through
				if (accept) begin
					if (req_i.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
							OP_SB, OP_SH, OP_SW}) begin
						state_d = S_ADDR;
					end else begin
						state_d = S_HOLD;
					end
				end
			end
			S_ADDR: begin
				if (is_load & ar_fire) begin
					state_d = S_DATA;
				end
				// both halves of the write done, now or earlier
				if (is_store & (aw_done_q | aw_fire) & (w_done_q | w_fire)) begin
					state_d = S_DATA;
				end
			end
			S_DATA: begin
				if (r_fire | b_fire) begin
					state_d = S_HOLD;
				end
			end
			default: begin
				if (rsp_ready_i) begin
					state_d = S_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q   <= S_IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			// flags only live inside the address phase
			if (state_q != S_ADDR || state_d != S_ADDR) begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
			end else begin
				aw_done_q <= aw_done_q | aw_fire;
				w_done_q  <= w_done_q | w_fire;
			end
		end
	end

	// request and result payload
	always_ff @(posedge clock) begin
		if (accept) begin
			req_q   <= req_i;
			wdata_q <= req_wdata_i;
			// pass-through result, overwritten by bus ops
			data_q  <= req_i.addr;
			err_q   <= 1'b0;
		end
		if (r_fire) begin
			data_q <= load_data;
			err_q  <= (bus.rresp != RESP_OKAY);
		end
		if (b_fire) begin
			data_q <= '0;
			err_q  <= (bus.bresp != RESP_OKAY);
		end
	end

	assign rsp_o = '{rd: req_q.rd, data: data_q, err: err_q};

endmodule

/* lsu_sram_slave.sv */
// word-addressed SRAM behind the bus slave port
// one transaction at a time, reads win if AR and AW/W arrive together
// response after MEM_LATENCY cycles, MEM_LATENCY must be 1 or more
// addresses at or past MEM_DEPTH words get SLVERR, no write, read data 0
`timescale 1ns/100ps

module lsu_sram_slave #(
	parameter int MEM_DEPTH   = 1024,
	parameter int MEM_LATENCY = 2
) (
	input  logic      clock,
	input  logic      rstn,
	lsu_axi_if.slave  bus
);
	import lsu_pkg::*;

	localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	logic [XLEN-1:0]  mem [MEM_DEPTH];

	logic             busy_q;
	logic             write_q;
	logic             err_q;
	logic [CNT_W-1:0] cnt_q;
	logic [XLEN-1:0]  rdata_q;

	logic             idle;
	logic             ar_fire;
	logic             w_fire;
	logic             done;
	logic [XLEN-1:0]  acc_addr;
	logic [IDX_W-1:0] acc_idx;
	logic             acc_err;

	assign idle = ~busy_q;

	// AW and W only taken as a pair
	assign bus.arready = idle & bus.arvalid;
	assign bus.awready = idle & bus.awvalid & bus.wvalid & ~bus.arvalid;
	assign bus.wready  = bus.awready;

	assign ar_fire = bus.arvalid & bus.arready;
	assign w_fire  = bus.awvalid & bus.awready;

	assign acc_addr = ar_fire ? bus.araddr : bus.awaddr;
	assign acc_idx  = acc_addr[IDX_W+1:2];

	// out of range word, or a size wider than the bus
	always_comb begin
		acc_err = (acc_addr[XLEN-1:2] >= (XLEN-2)'(MEM_DEPTH));
		if (ar_fire && bus.arsize > SIZE_4) begin
			acc_err = 1'b1;
		end
		if (!ar_fire && bus.awsize > SIZE_4) begin
			acc_err = 1'b1;
		end
	end

	// response once the countdown has run out
	assign bus.rvalid = busy_q & (cnt_q == '0) & ~write_q;
	assign bus.bvalid = busy_q & (cnt_q == '0) & write_q;
	assign bus.rdata  = rdata_q;
	assign bus.rresp  = err_q ? RESP_SLVERR : RESP_OKAY;
	assign bus.bresp  = err_q ? RESP_SLVERR : RESP_OKAY;

	assign done = (bus.rvalid & bus.rready) | (bus.bvalid & bus.bready);

	always_ff @(posedge clock) begin
		if (!rstn) begin
			busy_q  <= 1'b0;
			write_q <= 1'b0;
			err_q   <= 1'b0;
			cnt_q   <= '0;
		end else if (ar_fire | w_fire) begin
			busy_q  <= 1'b1;
			write_q <= w_fire;
			err_q   <= acc_err;
			cnt_q   <= CNT_W'(MEM_LATENCY - 1);
		end else if (busy_q) begin
			if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end else if (done) begin
				busy_q <= 1'b0;
			end
		end
	end

	// array access at acceptance, response waits out the latency
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			rdata_q <= acc_err ? '0 : mem[acc_idx];
		end
		if (w_fire && !acc_err) begin
			for (int b = 0; b < XLEN/8; b++) begin
				if (bus.wstrb[b]) begin
					mem[acc_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

/* lsu_top.sv */
// memory stage top, load/store unit with its SRAM
// plain valid/ready ports on both sides
// MEM_DEPTH in 32-bit words, MEM_LATENCY of 1 or more cycles
`timescale 1ns/100ps

module lsu_top #(
	parameter int MEM_DEPTH   = 1024,
	parameter int MEM_LATENCY = 2
) (
	input  logic                      clock,
	input  logic                      rstn,
	// request from execute
	input  logic                      req_valid_i,
	output logic                      req_ready_o,
	input  lsu_pkg::lsu_op_e          req_op_i,
	input  logic [lsu_pkg::XLEN-1:0]  req_addr_i,
	input  logic [lsu_pkg::XLEN-1:0]  req_wdata_i,
	input  logic [4:0]                req_rd_i,
	// result to write-back
	output logic                      rsp_valid_o,
	input  logic                      rsp_ready_i,
	output logic [4:0]                rsp_rd_o,
	output logic [lsu_pkg::XLEN-1:0]  rsp_data_o,
	output logic                      rsp_err_o
);
	import lsu_pkg::*;

	lsu_req_t req;
	lsu_rsp_t rsp;

	lsu_axi_if bus ();

	assign req = '{op: req_op_i, addr: req_addr_i, rd: req_rd_i};

	lsu_ctrl lsu_ctrl_i (
		.clock       (clock),
		.rstn        (rstn),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_i       (req),
		.req_wdata_i (req_wdata_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_o       (rsp),
		.bus         (bus.master)
	);

	lsu_sram_slave #(
		.MEM_DEPTH   (MEM_DEPTH),
		.MEM_LATENCY (MEM_LATENCY)
	) lsu_sram_slave_i (
		.clock (clock),
		.rstn  (rstn),
		.bus   (bus.slave)
	);

	assign rsp_rd_o   = rsp.rd;
	assign rsp_data_o = rsp.data;
	assign rsp_err_o  = rsp.err;

endmodule

/* lsu_tb_asserts.sv */
// handshake checks on the controller, bound into lsu_ctrl
// only the master-driven channels and the result port are covered
`timescale 1ns/100ps

module lsu_tb_asserts (
	input logic                     clock,
	input logic                     rstn,
	input logic                     arvalid_i,
	input logic                     arready_i,
	input logic [lsu_pkg::XLEN-1:0] araddr_i,
	input lsu_pkg::axi_size_e       arsize_i,
	input logic                     awvalid_i,
	input logic                     awready_i,
	input logic [lsu_pkg::XLEN-1:0] awaddr_i,
	input lsu_pkg::axi_size_e       awsize_i,
	input logic                     wvalid_i,
	input logic                     wready_i,
	input logic [lsu_pkg::XLEN-1:0] wdata_i,
	input logic [3:0]               wstrb_i,
	input logic                     rsp_valid_i,
	input logic                     rsp_ready_i,
	input lsu_pkg::lsu_rsp_t        rsp_i
);

	// AR held with its payload until taken
	ar_hold: assert property (@(posedge clock) disable iff (!rstn)
		arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arsize_i))
		else $error("AR valid or payload changed before its transfer");

	aw_hold: assert property (@(posedge clock) disable iff (!rstn)
		awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awsize_i))
		else $error("AW valid or payload changed before its transfer");

	w_hold: assert property (@(posedge clock) disable iff (!rstn)
		wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
		else $error("W valid or payload changed before its transfer");

	// one kind of access at a time
	ar_aw_excl: assert property (@(posedge clock) disable iff (!rstn)
		!(arvalid_i && awvalid_i))
		else $error("AR and AW valid in the same cycle");

	rsp_hold: assert property (@(posedge clock) disable iff (!rstn)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
		else $error("result dropped or changed while write-back stalled");

endmodule

bind lsu_ctrl lsu_tb_asserts lsu_tb_asserts_i (
	.clock       (clock),
	.rstn        (rstn),
	.arvalid_i   (bus.arvalid),
	.arready_i   (bus.arready),
	.araddr_i    (bus.araddr),
	.arsize_i    (bus.arsize),
	.awvalid_i   (bus.awvalid),
	.awready_i   (bus.awready),
	.awaddr_i    (bus.awaddr),
	.awsize_i    (bus.awsize),
	.wvalid_i    (bus.wvalid),
	.wready_i    (bus.wready),
	.wdata_i     (bus.wdata),
	.wstrb_i     (bus.wstrb),
	.rsp_valid_i (rsp_valid_o),
	.rsp_ready_i (rsp_ready_i),
	.rsp_i       (rsp_o)
);

/* lsu_tb.sv */
// table-driven testbench for the load/store unit with its SRAM
// store data comes from an LCG with a fixed seed
// loads only touch bytes that earlier rows have written
// misaligned accesses that cross a word are not exercised
`timescale 1ns/100ps

module lsu_tb;
	import lsu_pkg::*;

	localparam int MEM_DEPTH   = 64;
	localparam int MEM_LATENCY = 3;
	// cycles allowed for any single wait
	localparam int TIMEOUT     = 50;
	// first byte address past the SRAM
	localparam logic [31:0] OOR_BASE = 32'(MEM_DEPTH * 4);

	typedef struct {
		lsu_op_e     op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [4:0]  rd;
		// cycles write-back stalls the result
		int          hold;
		bit          exp_err;
	} row_t;

	logic        clock;
	logic        rstn;
	logic        req_valid_i;
	logic        req_ready_o;
	lsu_op_e     req_op_i;
	logic [31:0] req_addr_i;
	logic [31:0] req_wdata_i;
	logic [4:0]  req_rd_i;
	logic        rsp_valid_o;
	logic        rsp_ready_i;
	logic [4:0]  rsp_rd_o;
	logic [31:0] rsp_data_o;
	logic        rsp_err_o;

	row_t        rows[$];
	// reference memory, byte address to byte
	logic [7:0]  ref_mem [int];
	logic [31:0] lcg_state = 32'hce16;
	int          errors = 0;
	int          rows_failed = 0;
	int          rows_run = 0;
	bit          timed_out = 1'b0;

	lsu_top #(
		.MEM_DEPTH   (MEM_DEPTH),
		.MEM_LATENCY (MEM_LATENCY)
	) lsu_top_i (
		.clock       (clock),
		.rstn        (rstn),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_op_i    (req_op_i),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.req_rd_i    (req_rd_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_rd_o    (rsp_rd_o),
		.rsp_data_o  (rsp_data_o),
		.rsp_err_o   (rsp_err_o)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic add_row(input lsu_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [4:0] rd, input int hold,
			input bit exp_err);
		row_t r;
		r.op      = op;
		r.addr    = addr;
		r.wdata   = wdata;
		r.rd      = rd;
		r.hold    = hold;
		r.exp_err = exp_err;
		rows.push_back(r);
	endtask

	function automatic int access_bytes(input lsu_op_e op);
		case (op)
			OP_LB, OP_LBU, OP_SB: return 1;
			OP_LH, OP_LHU, OP_SH: return 2;
			OP_LW, OP_SW: return 4;
			default: return 0;
		endcase
	endfunction

	// byte i of the store data lands at address addr + i
	task automatic store_ref(input lsu_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata);
		int n;
		n = access_bytes(op);
		if (addr >= OOR_BASE) begin
			return;
		end
		for (int i = 0; i < n; i++) begin
			ref_mem[int'(addr) + i] = wdata[8*i +: 8];
		end
	endtask

	// gather the accessed bytes, then extend by the op
	function automatic logic [31:0] expected_load(input lsu_op_e op, input logic [31:0] addr);
		logic [31:0] v;
		int          n;
		v = '0;
		n = access_bytes(op);
		if (addr >= OOR_BASE) begin
			return '0;
		end
		for (int i = 0; i < n; i++) begin
			v[8*i +: 8] = ref_mem[int'(addr) + i];
		end
		case (op)
			OP_LB: v = {{24{v[7]}}, v[7:0]};
			OP_LH: v = {{16{v[15]}}, v[15:0]};
			default: v = v;
		endcase
		return v;
	endfunction

	task automatic report_mismatch(input int idx, input string what,
			input logic [31:0] got, input logic [31:0] exp);
		$display("Fail at %0t ns: row %0d %s is %08h, expected %08h", $time, idx, what, got, exp);
		errors++;
	endtask

	task automatic wait_req_ready();
		int n;
		n = 0;
		while (!req_ready_o && n < TIMEOUT) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (!req_ready_o) begin
			$display("Timed out after %0d cycles waiting for req_ready_o", TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_rsp_valid();
		int n;
		n = 0;
		while (!rsp_valid_o && n < TIMEOUT) begin
			@(posedge clock);
			#1;
			n++;
		end
		if (!rsp_valid_o) begin
			$display("Timed out after %0d cycles waiting for rsp_valid_o", TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_row(input int idx);
		row_t        r;
		lsu_op_e     op;
		logic [31:0] exp_data;
		logic [4:0]  held_rd;
		logic [31:0] held_data;
		logic        held_err;
		int          errs_before;
		r = rows[idx];
		op = r.op;
		errs_before = errors;
		wait_req_ready();
		if (timed_out) begin
			return;
		end
		req_valid_i = 1'b1;
		req_op_i    = r.op;
		req_addr_i  = r.addr;
		req_wdata_i = r.wdata;
		req_rd_i    = r.rd;
		@(posedge clock);
		#1;
		req_valid_i = 1'b0;
		// expected result from the reference model
		if (op == OP_NONE) begin
			exp_data = r.addr;
		end else if (op inside {OP_SB, OP_SH, OP_SW}) begin
			exp_data = '0;
			store_ref(op, r.addr, r.wdata);
		end else begin
			exp_data = expected_load(op, r.addr);
		end
		wait_rsp_valid();
		if (timed_out) begin
			return;
		end
		held_rd   = rsp_rd_o;
		held_data = rsp_data_o;
		held_err  = rsp_err_o;
		// write-back stall, result must not move
		repeat (r.hold) begin
			@(posedge clock);
			#1;
			assert (rsp_valid_o && rsp_rd_o === held_rd && rsp_data_o === held_data
					&& rsp_err_o === held_err) else begin
				$display("Fail at %0t ns: row %0d result changed while stalled", $time, idx);
				errors++;
			end
			assert (!req_ready_o) else begin
				$display("Fail at %0t ns: row %0d req_ready_o high during stall", $time, idx);
				errors++;
			end
		end
		assert (rsp_rd_o === r.rd) else report_mismatch(idx, "rd", 32'(rsp_rd_o), 32'(r.rd));
		assert (rsp_data_o === exp_data) else report_mismatch(idx, "data", rsp_data_o, exp_data);
		assert (rsp_err_o === r.exp_err) else
			report_mismatch(idx, "err", 32'(rsp_err_o), 32'(r.exp_err));
		rsp_ready_i = 1'b1;
		@(posedge clock);
		#1;
		rsp_ready_i = 1'b0;
		assert (!rsp_valid_o && req_ready_o) else begin
			$display("Fail at %0t ns: row %0d unit not idle after result taken", $time, idx);
			errors++;
		end
		rows_run++;
		if (errors != errs_before) begin
			rows_failed++;
		end
		$display("row %0d %s addr %08h rd %0d: %s", idx, op.name(), r.addr, r.rd,
			(errors == errs_before) ? "ok" : "FAILED");
	endtask

	initial begin
		clock       = 1'b0;
		rstn        = 1'b0;
		req_valid_i = 1'b0;
		req_op_i    = OP_NONE;
		req_addr_i  = '0;
		req_wdata_i = '0;
		req_rd_i    = '0;
		rsp_ready_i = 1'b0;

		// word store and load back
		add_row(OP_SW, 32'h00, next_rand(), 5'd1, 0, 1'b0);
		add_row(OP_LW, 32'h00, 32'h0, 5'd2, 0, 1'b0);
		add_row(OP_SW, 32'h04, next_rand(), 5'd0, 0, 1'b0);
		add_row(OP_SW, 32'h08, next_rand(), 5'd0, 0, 1'b0);
		// both signs in bytes and halfwords
		add_row(OP_SW, 32'h0c, 32'h80ff_7f01, 5'd0, 0, 1'b0);
		// sub-word stores at each offset
		// word read back after each, untouched lanes keep older data
		for (int k = 0; k < 4; k++) begin
			add_row(OP_SB, 32'h04 + k, next_rand(), 5'd3, 0, 1'b0);
			add_row(OP_LW, 32'h04, 32'h0, 5'd4, 0, 1'b0);
		end
		for (int k = 0; k < 3; k++) begin
			add_row(OP_SH, 32'h08 + k, next_rand(), 5'd5, 0, 1'b0);
			add_row(OP_LW, 32'h08, 32'h0, 5'd6, 0, 1'b0);
		end
		// extension rules
		for (int k = 0; k < 4; k++) begin
			add_row(OP_LB, 32'h0c + k, 32'h0, 5'd12, 0, 1'b0);
			add_row(OP_LBU, 32'h0c + k, 32'h0, 5'd13, 0, 1'b0);
		end
		for (int k = 0; k < 3; k++) begin
			add_row(OP_LH, 32'h0c + k, 32'h0, 5'd14, 0, 1'b0);
			add_row(OP_LHU, 32'h0c + k, 32'h0, 5'd15, 0, 1'b0);
		end
		// pass-through
		add_row(OP_NONE, 32'h1234_5678, 32'h0, 5'd7, 2, 1'b0);
		// out of range, aliases words 2 and 3 and must not write them
		add_row(OP_SW, OOR_BASE + 32'h08, next_rand(), 5'd8, 0, 1'b1);
		add_row(OP_SB, OOR_BASE + 32'h0d, next_rand(), 5'd8, 0, 1'b1);
		add_row(OP_LW, OOR_BASE, 32'h0, 5'd9, 0, 1'b1);
		add_row(OP_LW, 32'h08, 32'h0, 5'd9, 0, 1'b0);
		add_row(OP_LW, 32'h0c, 32'h0, 5'd9, 0, 1'b0);
		// write-back back-pressure
		add_row(OP_LW, 32'h04, 32'h0, 5'd10, 4, 1'b0);
		add_row(OP_SW, 32'h10, next_rand(), 5'd11, 3, 1'b0);
		add_row(OP_LHU, 32'h12, 32'h0, 5'd16, 5, 1'b0);

		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;
		assert (req_ready_o && !rsp_valid_o) else begin
			$display("Fail at %0t ns: wrong handshake levels after reset", $time);
			errors++;
		end

		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
			if (timed_out) begin
				break;
			end
		end

		$display("%0d of %0d rows run, %0d passed, %0d failed, %0d check errors",
			rows_run, rows.size(), rows_run - rows_failed, rows_failed, errors);
		if (timed_out || errors != 0) begin
			$display("Simulation failed");
		end else begin
			$display("Simulation completed successfully");
		end
		$finish;
	end

endmodule

/* lsu.f */
lsu_pkg.sv
lsu_axi_if.sv
lsu_data_align.sv
lsu_ctrl.sv
lsu_sram_slave.sv
lsu_top.sv
lsu_tb_asserts.sv
lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f lsu.f --top-module lsu_tb -Mdir obj_dir

# an assertion may stop the simulator with a non-zero status
status=0
./obj_dir/Vlsu_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation completed successfully" sim.log; then
	echo "run ended early, see sim.log"
	exit 1
fi
exit 0
